//--- mipsIsaPkg.sv
package mipsIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // overlay of one 32-bit instruction word
    typedef struct packed {
        logic [5:0] opcode;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrT;

    // immediate and jump target as slices of the instruction word
    localparam int immMsb    = 15;
    localparam int immLsb    = 0;
    localparam int targetMsb = 25;
    localparam int targetLsb = 0;

    localparam wordT resetVector = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;  // R-type, decoded by funct
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct codes under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluLui
    } aluOpT;

endpackage

//--- mipsPipePkg.sv
package mipsPipePkg;

    typedef struct packed {
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic                memToReg;    // writeback takes load data
        logic                aluSrcImm;   // B operand is the immediate
        logic                regDstRd;    // destination is rd, else rt
        logic                signExtend;
        mipsIsaPkg::aluOpT   aluOp;
    } ctrlT;

    typedef enum logic [1:0] {fromFile, fromMem, fromWb} fwdSelT;

    // next-PC source from decode
    localparam logic [1:0] pcSeq    = 2'd0;
    localparam logic [1:0] pcBranch = 2'd1;
    localparam logic [1:0] pcJump   = 2'd2;

    typedef struct packed {
        mipsIsaPkg::instrT instr;
        mipsIsaPkg::wordT  pcPlus4;
    } ifIdT;

    typedef struct packed {
        ctrlT                ctrl;
        mipsIsaPkg::wordT    rsValue;
        mipsIsaPkg::wordT    rtValue;
        mipsIsaPkg::wordT    imm;      // already extended
        logic [4:0]          shamt;
        mipsIsaPkg::regAddrT rs;
        mipsIsaPkg::regAddrT rt;
        mipsIsaPkg::regAddrT dest;
    } idExT;

    typedef struct packed {
        ctrlT                ctrl;
        mipsIsaPkg::wordT    aluResult;
        mipsIsaPkg::wordT    storeData;
        mipsIsaPkg::regAddrT dest;
    } exMemT;

    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        mipsIsaPkg::wordT    loadData;
        mipsIsaPkg::wordT    aluResult;
        mipsIsaPkg::regAddrT dest;
    } memWbT;

    // operand mux shared by the ID and EX forwarding paths
    function automatic mipsIsaPkg::wordT fwdMux(fwdSelT sel, mipsIsaPkg::wordT fileValue,
                                                mipsIsaPkg::wordT memValue,
                                                mipsIsaPkg::wordT wbValue);
        mipsIsaPkg::wordT value;
        case (sel)
            fromMem: value = memValue;
            fromWb:  value = wbValue;
            default: value = fileValue;
        endcase
        return value;
    endfunction

endpackage

//--- stageRegister.sv
module stageRegister #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            q <= '0;  // zero payload is a no-op bubble
        end else if (!stall) begin
            q <= d;
        end
    end

    // the core either holds a stage or bubbles it, never both at one boundary
    flushStallExclusive: assert property (
        @(posedge clock) disable iff (reset) !(flush && stall)
    ) else $error("stage register flushed and stalled together");

endmodule

//--- decodeControl.sv
module decodeControl (
    input  mipsIsaPkg::instrT  instr,
    input  mipsIsaPkg::wordT   rsValue,
    input  mipsIsaPkg::wordT   rtValue,
    output mipsPipePkg::ctrlT  ctrl,
    output logic [1:0]         pcSel
);

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    logic operandsEqual;

    assign operandsEqual = (rsValue == rtValue);  // forwarded values from ID

    always_comb begin
        ctrl = '0;  // unknown encodings fall through as a no-op
        case (instr.opcode)
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (instr.funct)
                    fnAddu:  ctrl.aluOp = aluAdd;
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnXor:   ctrl.aluOp = aluXor;
                    fnNor:   ctrl.aluOp = aluNor;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    fnSltu:  ctrl.aluOp = aluSltu;
                    fnSll:   ctrl.aluOp = aluSll;
                    fnSrl:   ctrl.aluOp = aluSrl;
                    default: ctrl = '0;
                endcase
            end
            opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExtend = (instr.opcode == opAddiu) || (instr.opcode == opSlti);
                case (instr.opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opLw: begin
                ctrl.regWrite   = 1'b1;
                ctrl.memRead    = 1'b1;
                ctrl.memToReg   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.signExtend = 1'b1;
            end
            opSw: begin
                ctrl.memWrite   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.signExtend = 1'b1;
            end
            default: ;  // beq, bne and j write nothing
        endcase
    end

    always_comb begin
        case (instr.opcode)
            opBeq:   pcSel = operandsEqual ? pcBranch : pcSeq;
            opBne:   pcSel = operandsEqual ? pcSeq : pcBranch;
            opJ:     pcSel = pcJump;
            default: pcSel = pcSeq;
        endcase
    end

endmodule

//--- hazardUnit.sv
module hazardUnit (
    input  mipsIsaPkg::regAddrT  idRs,
    input  mipsIsaPkg::regAddrT  idRt,
    input  logic                 idIsBranch,
    input  mipsPipePkg::idExT    exMemIn,     // instruction now in EX
    input  mipsPipePkg::exMemT   memStage,
    input  mipsPipePkg::memWbT   wbStage,
    output mipsPipePkg::fwdSelT  idRsSel,
    output mipsPipePkg::fwdSelT  idRtSel,
    output mipsPipePkg::fwdSelT  exRsSel,
    output mipsPipePkg::fwdSelT  exRtSel,
    output logic                 stall
);

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    logic memAluWrite;
    logic exLoadHit;
    logic exBranchHit;
    logic memBranchHit;

    // a write to register 0 never counts as a producer
    function automatic logic hits(logic writes, regAddrT dest, regAddrT src);
        return writes && (dest != '0) && (dest == src);
    endfunction

    function automatic fwdSelT pickSource(regAddrT src);
        fwdSelT sel;
        if (hits(memAluWrite, memStage.dest, src)) begin
            sel = fromMem;  // youngest producer wins
        end else if (hits(wbStage.regWrite, wbStage.dest, src)) begin
            sel = fromWb;
        end else begin
            sel = fromFile;
        end
        return sel;
    endfunction

    // MEM forwards only ALU results, load data is not ready for ID/EX yet
    assign memAluWrite = memStage.ctrl.regWrite && !memStage.ctrl.memRead;

    always_comb begin
        idRsSel = pickSource(idRs);
        idRtSel = pickSource(idRt);
        exRsSel = pickSource(exMemIn.rs);
        exRtSel = pickSource(exMemIn.rt);
    end

    always_comb begin
        exLoadHit = exMemIn.ctrl.memRead &&
                    (hits(1'b1, exMemIn.dest, idRs) || hits(1'b1, exMemIn.dest, idRt));
        exBranchHit = idIsBranch && (hits(exMemIn.ctrl.regWrite, exMemIn.dest, idRs) ||
                                     hits(exMemIn.ctrl.regWrite, exMemIn.dest, idRt));
        memBranchHit = idIsBranch && (hits(memStage.ctrl.memRead, memStage.dest, idRs) ||
                                      hits(memStage.ctrl.memRead, memStage.dest, idRt));
        stall = exLoadHit || exBranchHit || memBranchHit;
    end

    // a load into r0 in EX is no producer, only a load in MEM may still stall
    always_comb begin
        if (exMemIn.ctrl.memRead && (exMemIn.dest == '0) && !memStage.ctrl.memRead) begin
            zeroLoadNoStall: assert final (!stall)
                else $error("stall raised by a load into register 0");
        end
    end

endmodule

//--- registerFile.sv
module registerFile (
    input  logic                 clock,
    input  logic                 reset,
    input  mipsIsaPkg::regAddrT  readAddrA,
    input  mipsIsaPkg::regAddrT  readAddrB,
    input  mipsIsaPkg::regAddrT  writeAddr,
    input  logic                 writeEnable,
    input  mipsIsaPkg::wordT     writeData,
    output mipsIsaPkg::wordT     readDataA,
    output mipsIsaPkg::wordT     readDataB
);

    import mipsIsaPkg::*;

    wordT regs [1:31];  // r0 has no storage

    function automatic wordT readPort(regAddrT addr);
        wordT value;
        if (addr == '0) begin
            value = '0;
        end else if (writeEnable && (writeAddr == addr)) begin
            value = writeData;  // same-cycle write passes through
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            foreach (regs[i]) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    zeroRegister: assert property (
        @(posedge clock) disable iff (reset)
        ((readAddrA == '0) |-> (readDataA == '0)) and ((readAddrB == '0) |-> (readDataB == '0))
    ) else $error("register 0 read back nonzero");

endmodule

//--- executeAlu.sv
module executeAlu (
    input  mipsPipePkg::idExT    stage,
    input  mipsPipePkg::fwdSelT  exRsSel,
    input  mipsPipePkg::fwdSelT  exRtSel,
    input  mipsIsaPkg::wordT     memResult,
    input  mipsIsaPkg::wordT     wbResult,
    output mipsIsaPkg::wordT     result,
    output mipsIsaPkg::wordT     storeData
);

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    wordT opA;
    wordT rtFwd;
    wordT opB;

    always_comb begin
        opA   = fwdMux(exRsSel, stage.rsValue, memResult, wbResult);
        rtFwd = fwdMux(exRtSel, stage.rtValue, memResult, wbResult);
        opB   = stage.ctrl.aluSrcImm ? stage.imm : rtFwd;
    end

    assign storeData = rtFwd;  // sw data is rt, never the immediate

    always_comb begin
        case (stage.ctrl.aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluXor:  result = opA ^ opB;
            aluNor:  result = ~(opA | opB);
            aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            aluSltu: result = {31'b0, opA < opB};
            aluSll:  result = opB << stage.shamt;   // shifts act on rt
            aluSrl:  result = opB >> stage.shamt;
            aluLui:  result = {opB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

//--- mipsCore.sv
module mipsCore (
    input  logic              clock,
    input  logic              reset,
    output logic [29:0]       instrAddr,      // word address
    input  mipsIsaPkg::wordT  instrData,
    output logic [29:0]       dataAddr,       // word address
    output logic              dataRead,
    output logic              dataWrite,
    output mipsIsaPkg::wordT  dataWriteData,
    input  mipsIsaPkg::wordT  dataReadData
);

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    wordT       pc;
    wordT       pcPlus4;
    wordT       nextPc;
    logic       stall;

    ifIdT       ifIdD, ifIdQ;
    idExT       idExD, idExQ;
    exMemT      exMemD, exMemQ;
    memWbT      memWbD, memWbQ;

    wordT       idWord;
    ctrlT       idCtrl;
    logic [1:0] pcSel;
    logic       idIsBranch;
    wordT       idRsFile, idRtFile;
    wordT       idRsValue, idRtValue;
    fwdSelT     idRsSel, idRtSel, exRsSel, exRtSel;
    logic [15:0] imm16;
    wordT       extImm;
    wordT       branchTarget;
    wordT       jumpTarget;
    regAddrT    idDest;

    wordT       exResult;
    wordT       exStoreData;
    wordT       wbValue;

    // fetch
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= resetVector;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    assign pcPlus4   = pc + 32'd4;
    assign instrAddr = pc[31:2];

    always_comb begin
        case (pcSel)
            pcBranch: nextPc = branchTarget;
            pcJump:   nextPc = jumpTarget;
            default:  nextPc = pcPlus4;   // delay slot is already in IF
        endcase
    end

    assign ifIdD = '{instr: instrT'(instrData), pcPlus4: pcPlus4};

    stageRegister #(.payloadT(ifIdT)) ifIdReg (
        .clock (clock),
        .reset (reset),
        .stall (stall),
        .flush (1'b0),
        .d     (ifIdD),
        .q     (ifIdQ)
    );

    // decode
    assign idWord     = ifIdQ.instr;
    assign imm16      = idWord[immMsb:immLsb];
    assign idIsBranch = (ifIdQ.instr.opcode == opBeq) || (ifIdQ.instr.opcode == opBne);

    registerFile regFile (
        .clock       (clock),
        .reset       (reset),
        .readAddrA   (ifIdQ.instr.rs),
        .readAddrB   (ifIdQ.instr.rt),
        .writeAddr   (memWbQ.dest),
        .writeEnable (memWbQ.regWrite),
        .writeData   (wbValue),
        .readDataA   (idRsFile),
        .readDataB   (idRtFile)
    );

    // branch compare needs operands as fresh as possible
    assign idRsValue = fwdMux(idRsSel, idRsFile, exMemQ.aluResult, wbValue);
    assign idRtValue = fwdMux(idRtSel, idRtFile, exMemQ.aluResult, wbValue);

    decodeControl decoder (
        .instr   (ifIdQ.instr),
        .rsValue (idRsValue),
        .rtValue (idRtValue),
        .ctrl    (idCtrl),
        .pcSel   (pcSel)
    );

    assign extImm       = idCtrl.signExtend ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
    assign branchTarget = ifIdQ.pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpTarget   = {ifIdQ.pcPlus4[31:28], idWord[targetMsb:targetLsb], 2'b00};
    assign idDest       = idCtrl.regDstRd ? ifIdQ.instr.rd : ifIdQ.instr.rt;

    hazardUnit hazards (
        .idRs       (ifIdQ.instr.rs),
        .idRt       (ifIdQ.instr.rt),
        .idIsBranch (idIsBranch),
        .exMemIn    (idExQ),
        .memStage   (exMemQ),
        .wbStage    (memWbQ),
        .idRsSel    (idRsSel),
        .idRtSel    (idRtSel),
        .exRsSel    (exRsSel),
        .exRtSel    (exRtSel),
        .stall      (stall)
    );

    assign idExD = '{ctrl: idCtrl, rsValue: idRsValue, rtValue: idRtValue, imm: extImm,
                     shamt: ifIdQ.instr.shamt, rs: ifIdQ.instr.rs, rt: ifIdQ.instr.rt,
                     dest: idDest};

    stageRegister #(.payloadT(idExT)) idExReg (
        .clock (clock),
        .reset (reset),
        .stall (1'b0),
        .flush (stall),   // bubble while ID waits
        .d     (idExD),
        .q     (idExQ)
    );

    // execute
    executeAlu alu (
        .stage     (idExQ),
        .exRsSel   (exRsSel),
        .exRtSel   (exRtSel),
        .memResult (exMemQ.aluResult),
        .wbResult  (wbValue),
        .result    (exResult),
        .storeData (exStoreData)
    );

    assign exMemD = '{ctrl: idExQ.ctrl, aluResult: exResult, storeData: exStoreData,
                      dest: idExQ.dest};

    stageRegister #(.payloadT(exMemT)) exMemReg (
        .clock (clock),
        .reset (reset),
        .stall (1'b0),
        .flush (1'b0),
        .d     (exMemD),
        .q     (exMemQ)
    );

    // memory, the data port answers in the same cycle
    assign dataAddr      = exMemQ.aluResult[31:2];
    assign dataRead      = exMemQ.ctrl.memRead;
    assign dataWrite     = exMemQ.ctrl.memWrite;
    assign dataWriteData = exMemQ.storeData;

    assign memWbD = '{regWrite: exMemQ.ctrl.regWrite, memToReg: exMemQ.ctrl.memToReg,
                      loadData: dataReadData, aluResult: exMemQ.aluResult,
                      dest: exMemQ.dest};

    stageRegister #(.payloadT(memWbT)) memWbReg (
        .clock (clock),
        .reset (reset),
        .stall (1'b0),
        .flush (1'b0),
        .d     (memWbD),
        .q     (memWbQ)
    );

    // writeback
    assign wbValue = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

    dataStrobesExclusive: assert property (
        @(posedge clock) disable iff (reset) !(dataRead && dataWrite)
    ) else $error("data port read and write strobes high together");

endmodule

//--- tbClock.sv
module tbClock #(
    parameter int resetCycles = 8
) (
    output logic clock,
    output logic reset = 1'b1,
    input  logic restart
);

    timeunit 1ns;
    timeprecision 100ps;

    int count = resetCycles;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    // restart holds reset high for resetCycles rising edges
    always @(posedge clock) begin
        if (restart) begin
            reset <= 1'b1;
            count <= resetCycles - 1;
        end else if (count > 0) begin
            count <= count - 1;
        end else begin
            reset <= 1'b0;
        end
    end

endmodule

//--- tbChecker.sv
module tbChecker (
    input logic              clock,
    input logic              reset,
    input logic [29:0]       instrAddr,
    input logic              dataRead,
    input logic              dataWrite,
    input logic [29:0]       dataAddr,
    input mipsIsaPkg::wordT  dataWriteData
);

    timeunit 1ns;
    timeprecision 100ps;

    import mipsIsaPkg::*;

    int          errorCount = 0;
    int          expectedCount = 0;
    int          seenCount = 0;
    int          expectedLoads = 0;
    int          loadsSeen = 0;
    logic [29:0] expAddr [$];
    wordT        expData [$];
    logic [29:0] expLoad [$];
    logic        prevReset = 1'b0;

    // ISA model with sequential execution and one delay slot after each branch or jump
    task automatic loadProgram(input wordT prog [256]);
        wordT    regs [32];
        wordT    mem [64];
        wordT    pc;
        wordT    npc;
        wordT    cur;
        wordT    w;
        wordT    a;
        wordT    b;
        wordT    res;
        wordT    sImm;
        wordT    zImm;
        wordT    ea;
        wordT    target;
        instrT   ins;
        logic    writes;
        regAddrT dest;
        logic    stop;
        expAddr.delete();
        expData.delete();
        expLoad.delete();
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        pc = resetVector;
        npc = resetVector + 32'd4;
        stop = 1'b0;
        for (int step = 0; step < 4096 && !stop; step++) begin
            cur = pc;
            w = prog[cur[9:2]];
            ins = instrT'(w);
            pc = npc;
            npc = npc + 32'd4;
            a = regs[ins.rs];
            b = regs[ins.rt];
            sImm = {{16{w[15]}}, w[15:0]};
            zImm = {16'h0000, w[15:0]};
            ea = a + sImm;
            writes = 1'b1;
            dest = ins.rt;
            res = '0;
            case (ins.opcode)
                opSpecial: begin
                    dest = ins.rd;
                    case (ins.funct)
                        fnAddu:  res = a + b;
                        fnSubu:  res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnXor:   res = a ^ b;
                        fnNor:   res = ~(a | b);
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSltu:  res = (a < b) ? 32'd1 : 32'd0;
                        fnSll:   res = b << ins.shamt;
                        fnSrl:   res = b >> ins.shamt;
                        default: writes = 1'b0;
                    endcase
                end
                opAddiu: res = a + sImm;
                opSlti:  res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                opAndi:  res = a & zImm;
                opOri:   res = a | zImm;
                opXori:  res = a ^ zImm;
                opLui:   res = {w[15:0], 16'h0000};
                opLw: begin
                    res = mem[ea[7:2]];
                    expLoad.push_back(ea[31:2]);
                end
                opSw: begin
                    writes = 1'b0;
                    mem[ea[7:2]] = b;
                    expAddr.push_back(ea[31:2]);
                    expData.push_back(b);
                end
                opBeq: begin
                    writes = 1'b0;
                    if (a == b) npc = cur + 32'd4 + (sImm << 2);
                end
                opBne: begin
                    writes = 1'b0;
                    if (a != b) npc = cur + 32'd4 + (sImm << 2);
                end
                opJ: begin
                    writes = 1'b0;
                    target = {pc[31:28], w[25:0], 2'b00};
                    npc = target;
                    stop = (target == cur);  // self-jump ends the program
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != '0) regs[dest] = res;
        end
        expectedCount = expAddr.size();
        expectedLoads = expLoad.size();
        seenCount = 0;
        loadsSeen = 0;
    endtask

    always @(posedge clock) begin
        if (reset && prevReset && (dataRead || dataWrite)) begin
            $display("[ERROR] %0t: data strobe high during reset", $time);
            errorCount++;
        end
        if (!reset && prevReset && instrAddr != 30'd0) begin
            $display("[ERROR] %0t: first fetch at %h, expected reset vector", $time, instrAddr);
            errorCount++;
        end
        if (!reset && dataRead) begin
            if (loadsSeen >= expectedLoads) begin
                $display("extra load from word %h beyond the %0d the model made",
                         dataAddr, expectedLoads);
                errorCount++;
            end else if (dataAddr != expLoad[loadsSeen]) begin
                $display("[ERROR] %0t: load %0d from word %h, expected word %h", $time,
                         loadsSeen, dataAddr, expLoad[loadsSeen]);
                errorCount++;
            end
            loadsSeen++;
        end
        if (!reset && dataWrite) begin
            if (seenCount >= expectedCount) begin
                $display("extra store to word %h beyond the %0d the model made",
                         dataAddr, expectedCount);
                errorCount++;
            end else if (dataAddr != expAddr[seenCount] || dataWriteData != expData[seenCount]) begin
                $display("[ERROR] %0t: store %0d got %h <= %h, expected %h <= %h", $time,
                         seenCount, dataAddr, dataWriteData, expAddr[seenCount],
                         expData[seenCount]);
                errorCount++;
            end
            seenCount++;
        end
        prevReset <= reset;
    end

endmodule

//--- tbMipsCore.sv
module tbMipsCore;

    timeunit 1ns;
    timeprecision 100ps;

    import mipsIsaPkg::*;

    localparam int bodyLen     = 60;
    localparam int progLen     = bodyLen + 33;  // body, 31 stores, self-jump, nop
    localparam int numTests    = 5;
    localparam int resetCycles = 8;

    logic        clock;
    logic        reset;
    logic        restart;
    logic [29:0] instrAddr;
    logic [29:0] dataAddr;
    logic        dataRead;
    logic        dataWrite;
    wordT        instrData;
    wordT        dataWriteData;
    wordT        dataReadData;

    wordT   imem [256] = '{default: '0};
    wordT   dmem [64] = '{default: '0};
    integer seed = 32'hba9e;
    int     passCount = 0;
    int     failCount = 0;

    tbClock #(.resetCycles(resetCycles)) clockGen (
        .clock   (clock),
        .reset   (reset),
        .restart (restart)
    );

    mipsCore mipsCore_inst (
        .clock         (clock),
        .reset         (reset),
        .instrAddr     (instrAddr),
        .instrData     (instrData),
        .dataAddr      (dataAddr),
        .dataRead      (dataRead),
        .dataWrite     (dataWrite),
        .dataWriteData (dataWriteData),
        .dataReadData  (dataReadData)
    );

    tbChecker storeChecker (
        .clock         (clock),
        .reset         (reset),
        .instrAddr     (instrAddr),
        .dataRead      (dataRead),
        .dataWrite     (dataWrite),
        .dataAddr      (dataAddr),
        .dataWriteData (dataWriteData)
    );

    // both memories answer in the same cycle
    assign instrData    = imem[instrAddr[7:0]];
    assign dataReadData = dmem[dataAddr[5:0]];

    always @(posedge clock) begin
        if (reset) begin
            foreach (dmem[i]) dmem[i] <= '0;
        end else if (dataWrite) begin
            dmem[dataAddr[5:0]] <= dataWriteData;
        end
    end

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % 32'(n));
    endfunction

    function automatic wordT rType(logic [5:0] funct, regAddrT rd, regAddrT rs, regAddrT rt,
                                   logic [4:0] shamt);
        return {opSpecial, rs, rt, rd, shamt, funct};
    endfunction

    function automatic wordT iType(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic regAddrT anyReg(int test);
        return regAddrT'(pick(test == 5 ? 4 : 8));  // small set keeps dependencies close
    endfunction

    task automatic makeProgram(input int test);
        logic [5:0] functs [10] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
                                    fnSll, fnSrl};
        logic [5:0] immOps [6]  = '{opAddiu, opSlti, opAndi, opOri, opXori, opLui};
        int         weights [5];
        int         total;
        int         r;
        int         k;
        logic       lastCtrl;
        case (test)
            1:       weights = '{6, 3, 0, 0, 0};
            2:       weights = '{1, 8, 0, 0, 0};
            3:       weights = '{3, 2, 5, 0, 0};
            4:       weights = '{3, 3, 1, 3, 0};
            default: weights = '{3, 3, 1, 1, 2};
        endcase
        total = weights[0] + weights[1] + weights[2] + weights[3] + weights[4];
        foreach (imem[i]) imem[i] = '0;
        lastCtrl = 1'b0;
        for (int i = 0; i < bodyLen; i++) begin
            r = pick(total);
            if (lastCtrl && r >= weights[0] + weights[1] + weights[2]) r = 0;  // no jump in a slot
            lastCtrl = 1'b0;
            if (r < weights[0]) begin
                imem[i] = rType(functs[pick(10)], anyReg(test), anyReg(test), anyReg(test),
                                5'(pick(32)));
            end else if (r < weights[0] + weights[1]) begin
                imem[i] = iType(immOps[pick(6)], anyReg(test), anyReg(test), 16'(pick(65536)));
            end else if (r < weights[0] + weights[1] + weights[2]) begin
                // loads and stores share words 32 to 47 away from the final dump
                imem[i] = iType(pick(2) == 0 ? opLw : opSw, 5'd0, anyReg(test),
                                16'(4 * (32 + pick(16))));
            end else if (r < total - weights[4]) begin
                k = 1 + pick(4);
                if (i + 1 + k > bodyLen) k = bodyLen - i - 1;
                imem[i] = iType(pick(2) == 0 ? opBeq : opBne, anyReg(test), anyReg(test),
                                16'(k));
                lastCtrl = 1'b1;
            end else begin
                k = i + 2 + pick(3);
                if (k > bodyLen) k = bodyLen;
                imem[i] = {opJ, 26'(k)};
                lastCtrl = 1'b1;
            end
        end
        for (int regNum = 1; regNum < 32; regNum++) begin
            imem[bodyLen + regNum - 1] = iType(opSw, 5'd0, regAddrT'(regNum),
                                               16'(4 * (regNum - 1)));
        end
        imem[bodyLen + 31] = {opJ, 26'(bodyLen + 31)};  // self-jump with a nop after it
    endtask

    task automatic runTest(input int test, input string name);
        int errorsBefore;
        errorsBefore = storeChecker.errorCount;
        restart <= 1'b1;
        @(posedge clock);
        restart <= 1'b0;
        @(negedge clock);
        makeProgram(test);
        storeChecker.loadProgram(imem);
        while (reset) @(negedge clock);
        while (storeChecker.seenCount < storeChecker.expectedCount) @(negedge clock);
        repeat (10) @(negedge clock);  // room for stray stores
        if (storeChecker.seenCount != storeChecker.expectedCount) begin
            $display("test %0d: %0d stores seen, model made %0d", test,
                     storeChecker.seenCount, storeChecker.expectedCount);
        end
        if (storeChecker.loadsSeen != storeChecker.expectedLoads) begin
            $display("test %0d: %0d loads seen, model made %0d", test,
                     storeChecker.loadsSeen, storeChecker.expectedLoads);
        end
        if (storeChecker.errorCount == errorsBefore &&
            storeChecker.seenCount == storeChecker.expectedCount &&
            storeChecker.loadsSeen == storeChecker.expectedLoads) begin
            passCount++;
            $display("test %0d %s: pass, %0d stores", test, name, storeChecker.seenCount);
        end else begin
            failCount++;
            $display("test %0d %s: FAIL, %0d errors", test, name,
                     storeChecker.errorCount - errorsBefore);
        end
    endtask

    // each test gets three cycles per instruction plus slack
    initial begin
        repeat (numTests * (progLen * 3 + 100 + resetCycles + 20)) @(posedge clock);
        $display("watchdog expired before all tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        restart = 1'b0;
        runTest(1, "alu forwarding");
        runTest(2, "immediate extension");
        runTest(3, "load use");
        runTest(4, "branches and delay slots");
        runTest(5, "jumps and r0 writes");
        $display("passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- mipsCore.f
mipsIsaPkg.sv
mipsPipePkg.sv
stageRegister.sv
decodeControl.sv
hazardUnit.sv
registerFile.sv
executeAlu.sv
mipsCore.sv
tbClock.sv
tbChecker.sv
tbMipsCore.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -j 0 -f mipsCore.f --top-module tbMipsCore -o simv
	./obj_dir/simv | tee sim.log
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
